//--- Bender.yml
package:
  name: sp_subsys

export_include_dirs:
  - .

sources:
  - sp_pkg.sv
  - sp_bus_decode.sv
  - sp_narrow_bridge.sv
  - sp_scratch_mem.sv
  - sp_mmio_regs.sv
  - sp_top.sv
  - target: test
    files:
      - tb_sp_top.sv

//--- sources.f
+incdir+.
sp_pkg.sv
sp_bus_decode.sv
sp_narrow_bridge.sv
sp_scratch_mem.sv
sp_mmio_regs.sv
sp_top.sv
tb_sp_top.sv

//--- sp_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "sp_cfg.svh"

module sp_bus_decode (
   input  wire              clk,
   input  wire              arst_n_i,
   input  sp_pkg::sp_req_t  req_i,
   output sp_pkg::sp_rsp_t  rsp_o,
   output sp_pkg::sp_req_t  mem_req_o,
   output sp_pkg::sp_req_t  brg_req_o,
   output sp_pkg::sp_req_t  reg_req_o,
   input  sp_pkg::sp_rsp_t  mem_rsp_i,
   input  sp_pkg::sp_rsp_t  brg_rsp_i,
   input  sp_pkg::sp_rsp_t  reg_rsp_i
);
   import sp_pkg::*;

   logic    mem_hit;
   logic    brg_hit;
   logic    reg_hit;
   logic    unm_hit;
   sp_rsp_t unm_rsp;

   assign mem_hit = ~req_i.adr[31];
   assign brg_hit = (req_i.adr[31:24] == `SP_NARROW_PAGE);
   assign reg_hit = (req_i.adr[31:24] == `SP_MMIO_PAGE);
   assign unm_hit = ~(mem_hit | brg_hit | reg_hit);

   // Unmapped space answers at once with zero data.
   assign unm_rsp.dat = '0;
   assign unm_rsp.ack = req_i.cyc & req_i.stb & unm_hit;

   always_comb begin
      mem_req_o     = req_i;
      brg_req_o     = req_i;
      reg_req_o     = req_i;
      mem_req_o.stb = req_i.stb & mem_hit;
      brg_req_o.stb = req_i.stb & brg_hit;
      brg_req_o.cyc = req_i.cyc & brg_hit; // Narrow cycle only for its own page.
      reg_req_o.stb = req_i.stb & reg_hit;
   end

   always_comb begin
      if (mem_hit) begin
         rsp_o = mem_rsp_i;
      end else if (brg_hit) begin
         rsp_o = brg_rsp_i;
      end else if (reg_hit) begin
         rsp_o = reg_rsp_i;
      end else begin
         rsp_o = unm_rsp;
      end
   end

   // Targets never acknowledge together.
   a_one_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0({mem_rsp_i.ack, brg_rsp_i.ack, reg_rsp_i.ack, unm_rsp.ack}));

endmodule

`default_nettype wire

//--- sp_cfg.svh
`ifndef SP_CFG_SVH
`define SP_CFG_SVH

// Address map. The page is the top byte of the processor address.
// Scratch RAM lives at every address whose top bit is clear.
`define SP_NARROW_PAGE 8'h80
`define SP_MMIO_PAGE   8'hFF

// Scratch RAM depth in 32-bit words.
`define SP_MEM_WORDS 256

// MMIO register offsets, low address byte.
`define SP_REG_LED     8'h00
`define SP_REG_RST     8'h04
`define SP_REG_SCRATCH 8'h08
`define SP_REG_ID      8'h0C

// Width of the soft-reset pulse vector.
`define SP_RST_BITS 5

// Read-only device ID.
`define SP_DEVICE_ID 32'h5350_0001

`endif

//--- sp_mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sp_cfg.svh"

module sp_mmio_regs (
   input  wire                     clk,
   input  wire                     arst_n_i,
   input  sp_pkg::sp_req_t         req_i,
   output sp_pkg::sp_rsp_t         rsp_o,
   output logic                    led_green_o,
   output logic                    led_red_o,
   output logic [`SP_RST_BITS-1:0] sw_reset_o
);
   import sp_pkg::*;

   logic [1:0]              led_q;
   logic [`SP_RST_BITS-1:0] rst_q;
   sp_word_t                scratch_q;
   sp_word_t                rdata_q;
   sp_word_t                rdata;
   logic                    ack_q;
   logic                    access;
   logic                    wr;

   assign access = req_i.cyc & req_i.stb & ~ack_q;
   assign wr     = access & req_i.we;

   always_comb begin
      case (req_i.adr[7:0])
         `SP_REG_LED:     rdata = {30'd0, led_q};
         `SP_REG_SCRATCH: rdata = scratch_q;
         `SP_REG_ID:      rdata = `SP_DEVICE_ID;
         default:         rdata = '0; // RST and holes read zero.
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         led_q <= 2'b00;
         rst_q <= '0;
      end else begin
         ack_q <= access;
         rst_q <= '0;   // Pulse lasts a single cycle.
         if (wr && req_i.sel[0]) begin
            if (req_i.adr[7:0] == `SP_REG_LED) begin
               led_q <= req_i.dat[1:0];
            end
            if (req_i.adr[7:0] == `SP_REG_RST) begin
               rst_q <= req_i.dat[`SP_RST_BITS-1:0];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr && req_i.adr[7:0] == `SP_REG_SCRATCH) begin
         for (int i = 0; i < 4; i++) begin
            if (req_i.sel[i]) begin
               scratch_q[8*i +: 8] <= req_i.dat[8*i +: 8];
            end
         end
      end
      if (access) begin
         rdata_q <= rdata;
      end
   end

   assign led_green_o = led_q[0];
   assign led_red_o   = led_q[1];
   assign sw_reset_o  = rst_q;
   assign rsp_o.dat   = rdata_q;
   assign rsp_o.ack   = ack_q;

   // Soft reset is a single-cycle pulse.
   a_rst_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
      (sw_reset_o != '0) |=> (sw_reset_o == '0));

endmodule

`default_nettype wire

//--- sp_narrow_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module sp_narrow_bridge (
   input  wire              clk,
   input  wire              arst_n_i,
   input  sp_pkg::sp_req_t  req_i,
   output sp_pkg::sp_rsp_t  rsp_o,
   output sp_pkg::sp_nadr_t nb_adr_o,
   output sp_pkg::sp_byte_t nb_dat_o,
   input  sp_pkg::sp_byte_t nb_dat_i,
   output logic             nb_we_o,
   output logic             nb_sel_o,
   output logic             nb_stb_o,
   output logic             nb_cyc_o,
   input  wire              nb_ack_i
);
   import sp_pkg::*;

   logic [1:0] lane_q;    // Byte lane in progress.
   logic       ack_q;
   sp_word_t   asm_q;     // Read word assembled MSB first.
   logic       active;
   logic       byte_done;

   assign active    = req_i.cyc & req_i.stb;
   assign byte_done = nb_stb_o & nb_ack_i;

   assign nb_adr_o = {req_i.adr[23:2], lane_q};
   assign nb_we_o  = req_i.we;
   assign nb_cyc_o = req_i.cyc;
   assign nb_stb_o = active & ~ack_q; // No fifth byte while ack goes back.

   // Lane 0 carries the most significant byte.
   always_comb begin
      case (lane_q)
         2'd0: begin
            nb_dat_o = req_i.dat[31:24];
            nb_sel_o = req_i.sel[3];
         end
         2'd1: begin
            nb_dat_o = req_i.dat[23:16];
            nb_sel_o = req_i.sel[2];
         end
         2'd2: begin
            nb_dat_o = req_i.dat[15:8];
            nb_sel_o = req_i.sel[1];
         end
         default: begin
            nb_dat_o = req_i.dat[7:0];
            nb_sel_o = req_i.sel[0];
         end
      endcase
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lane_q <= 2'd0;
         ack_q  <= 1'b0;
      end else if (ack_q || !active) begin
         lane_q <= 2'd0;   // Finished or withdrawn.
         ack_q  <= 1'b0;
      end else if (byte_done) begin
         lane_q <= lane_q + 2'd1;
         ack_q  <= (lane_q == 2'd3);
      end
   end

   always_ff @(posedge clk) begin
      if (byte_done) begin
         asm_q <= {asm_q[23:0], nb_dat_i};
      end
   end

   assign rsp_o.dat = asm_q;
   assign rsp_o.ack = ack_q;

   // A narrow ack only answers a live byte strobe.
   a_nb_ack_in_byte: assert property (@(posedge clk) disable iff (!arst_n_i)
      nb_ack_i |-> nb_stb_o);

endmodule

`default_nettype wire

//--- sp_pkg.sv
`default_nettype none

package sp_pkg;

   // Processor byte address.
   typedef logic [31:0] sp_addr_t;

   // Data word, big-endian lanes: lane 0 is bits 31:24.
   typedef logic [31:0] sp_word_t;

   // Narrow bus data.
   typedef logic [7:0] sp_byte_t;

   // Byte-lane selects, bit 3 is lane 0.
   typedef logic [3:0] sp_sel_t;

   // Narrow bus byte address.
   typedef logic [23:0] sp_nadr_t;

   // One Wishbone classic request from the master side.
   typedef struct packed {
      sp_addr_t adr;
      sp_word_t dat;
      sp_sel_t  sel;
      logic     we;
      logic     stb;
      logic     cyc;
   } sp_req_t;

   // One Wishbone classic response from the slave side.
   typedef struct packed {
      sp_word_t dat;
      logic     ack;
   } sp_rsp_t;

endpackage

`default_nettype wire

//--- sp_scratch_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "sp_cfg.svh"

module sp_scratch_mem (
   input  wire             clk,
   input  wire             arst_n_i,
   input  sp_pkg::sp_req_t req_i,
   output sp_pkg::sp_rsp_t rsp_o
);
   import sp_pkg::*;

   localparam int AW = $clog2(`SP_MEM_WORDS);

   sp_word_t          mem_q [`SP_MEM_WORDS];
   sp_word_t          rdata_q;
   logic              ack_q;
   logic              access;
   logic [AW-1:0]     idx;

   // A held strobe is served once.
   assign access = req_i.cyc & req_i.stb & ~ack_q;
   assign idx    = req_i.adr[AW+1:2]; // Word index.

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            for (int i = 0; i < 4; i++) begin
               if (req_i.sel[i]) begin
                  mem_q[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
               end
            end
         end
         rdata_q <= mem_q[idx];
      end
   end

   assign rsp_o.dat = rdata_q;
   assign rsp_o.ack = ack_q;

endmodule

`default_nettype wire

//--- sp_top.sv
`timescale 1ns/1ps
`default_nettype none

module sp_top (
   input  wire              clk,
   input  wire              arst_n_i,
   input  sp_pkg::sp_req_t  req_i,
   output sp_pkg::sp_rsp_t  rsp_o,
   output sp_pkg::sp_nadr_t nb_adr_o,
   output sp_pkg::sp_byte_t nb_dat_o,
   input  sp_pkg::sp_byte_t nb_dat_i,
   output wire              nb_we_o,
   output wire              nb_sel_o,
   output wire              nb_stb_o,
   output wire              nb_cyc_o,
   input  wire              nb_ack_i,
   output wire              led_green_o,
   output wire              led_red_o,
   output wire [4:0]        sw_reset_o
);
   import sp_pkg::*;

   sp_req_t mem_req;
   sp_req_t brg_req;
   sp_req_t reg_req;
   sp_rsp_t mem_rsp;
   sp_rsp_t brg_rsp;
   sp_rsp_t reg_rsp;

   sp_bus_decode u_decode (
      .clk(clk), .arst_n_i(arst_n_i),
      .req_i(req_i), .rsp_o(rsp_o),
      .mem_req_o(mem_req), .brg_req_o(brg_req), .reg_req_o(reg_req),
      .mem_rsp_i(mem_rsp), .brg_rsp_i(brg_rsp), .reg_rsp_i(reg_rsp)
   );

   sp_narrow_bridge u_bridge (
      .clk(clk), .arst_n_i(arst_n_i),
      .req_i(brg_req), .rsp_o(brg_rsp),
      .nb_adr_o(nb_adr_o), .nb_dat_o(nb_dat_o), .nb_dat_i(nb_dat_i),
      .nb_we_o(nb_we_o), .nb_sel_o(nb_sel_o), .nb_stb_o(nb_stb_o),
      .nb_cyc_o(nb_cyc_o), .nb_ack_i(nb_ack_i)
   );

   sp_scratch_mem u_mem (
      .clk(clk), .arst_n_i(arst_n_i), .req_i(mem_req), .rsp_o(mem_rsp)
   );

   sp_mmio_regs u_regs (
      .clk(clk), .arst_n_i(arst_n_i), .req_i(reg_req), .rsp_o(reg_rsp),
      .led_green_o(led_green_o), .led_red_o(led_red_o), .sw_reset_o(sw_reset_o)
   );

endmodule

`default_nettype wire

//--- tb_sp_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sp_cfg.svh"

module tb_sp_top;
   import sp_pkg::*;

   localparam int MAX_CYCLES = 2000;

   logic       clk;
   logic       arst_n = 1'b0;
   sp_req_t    req = '0;
   sp_rsp_t    rsp;
   sp_nadr_t   nb_adr;
   sp_byte_t   nb_dat_out;
   sp_byte_t   nb_dat_in = '0;
   logic       nb_we;
   logic       nb_sel;
   logic       nb_stb;
   logic       nb_cyc;
   logic       nb_ack = 1'b0;
   logic       led_green;
   logic       led_red;
   logic [4:0] sw_reset;

   integer     seed = 20;
   int         errors = 0;       // Errors in the running test.
   int         pass_cnt = 0;
   int         fail_cnt = 0;
   int         cycles = 0;
   int         nb_wait = 0;
   int         rst_pulses = 0;
   logic [4:0] rst_value = '0;
   sp_nadr_t   nb_last_adr = '0; // Address of the last narrow byte served.
   sp_byte_t   nb_mem [256];     // Narrow slave storage.
   sp_word_t   shadow [`SP_MEM_WORDS];

   sp_top uut (
      .clk(clk), .arst_n_i(arst_n), .req_i(req), .rsp_o(rsp),
      .nb_adr_o(nb_adr), .nb_dat_o(nb_dat_out), .nb_dat_i(nb_dat_in),
      .nb_we_o(nb_we), .nb_sel_o(nb_sel), .nb_stb_o(nb_stb), .nb_cyc_o(nb_cyc),
      .nb_ack_i(nb_ack), .led_green_o(led_green), .led_red_o(led_red),
      .sw_reset_o(sw_reset)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic sp_byte_t fill_byte(input int a);
      return a[7:0] ^ 8'hA5;
   endfunction

   function automatic int word_idx(input sp_addr_t a);
      return (a >> 2) % `SP_MEM_WORDS;
   endfunction

   // Lane i of the select covers data bits 8*i+7 down to 8*i.
   function automatic sp_word_t merge_lanes(input sp_word_t old, input sp_word_t d,
                                            input sp_sel_t s);
      sp_word_t res;
      res = old;
      for (int i = 0; i < 4; i++) begin
         if (s[i]) res[8*i +: 8] = d[8*i +: 8];
      end
      return res;
   endfunction

   task automatic check_word(input string what, input sp_word_t got, input sp_word_t exp);
      assert (got === exp) else begin
         $display("FAILED at time %0t: %s returned %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic flag_protocol(input string msg);
      $display("Protocol violation at time %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic end_test(input string name);
      if (errors == 0) pass_cnt++;
      else fail_cnt++;
      $display("Test %s: %s", name, (errors == 0) ? "passed" : "failed");
      errors = 0;
   endtask

   // One classic cycle held until ack.
   task automatic run_cycle(input sp_addr_t addr, input sp_word_t wdata, input sp_sel_t lanes,
                            input logic write, output sp_word_t rdata);
      @(negedge clk);
      req <= '{adr: addr, dat: wdata, sel: lanes, we: write, stb: 1'b1, cyc: 1'b1};
      do begin
         @(negedge clk);
      end while (!rsp.ack);
      rdata = rsp.dat;
      req  <= '0;
   endtask

   task automatic write_word(input sp_addr_t addr, input sp_word_t wdata, input sp_sel_t lanes);
      sp_word_t unused;
      run_cycle(addr, wdata, lanes, 1'b1, unused);
   endtask

   task automatic read_word(input sp_addr_t addr, output sp_word_t rdata);
      run_cycle(addr, '0, 4'hF, 1'b0, rdata);
   endtask

   initial begin
      for (int i = 0; i < 256; i++) nb_mem[i] = fill_byte(i);
   end

   // Narrow slave with a random 0 to 3 cycle delay per byte.
   always @(negedge clk) begin
      if (nb_ack) begin
         nb_ack  <= 1'b0;
         nb_wait = $random(seed) & 3;
      end else if (nb_stb && nb_cyc) begin
         if (nb_wait == 0) begin
            if (nb_we && nb_sel) nb_mem[nb_adr[7:0]] = nb_dat_out;
            nb_dat_in   <= nb_mem[nb_adr[7:0]];
            nb_last_adr <= nb_adr;
            nb_ack      <= 1'b1;
         end else begin
            nb_wait = nb_wait - 1;
         end
      end
   end

   always @(negedge clk) begin
      if (sw_reset != '0) begin
         rst_pulses <= rst_pulses + 1;
         rst_value  <= sw_reset;
      end
   end

   a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
      rsp.ack |=> !rsp.ack) else flag_protocol("ack stayed high for more than one cycle");
   a_no_stb_at_ack: assert property (@(posedge clk) disable iff (!arst_n)
      rsp.ack |-> !nb_stb) else flag_protocol("narrow strobe high while ack returned");
   a_nb_ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      nb_ack |-> nb_stb && nb_cyc) else flag_protocol("narrow ack outside a byte cycle");

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   initial begin
      sp_addr_t adrs [10];
      sp_word_t wdat;
      sp_word_t rdat;
      sp_sel_t  sel;
      repeat (2) @(negedge clk);
      arst_n <= 1'b1;
      check_word("reset state", {rsp.ack, uut.mem_rsp.ack, uut.brg_rsp.ack, uut.reg_rsp.ack,
                 nb_stb, nb_cyc, led_green, led_red, sw_reset}, '0);
      end_test("reset state");

      for (int i = 0; i < 10; i++) begin
         if (i == 9) begin
            adrs[i] = adrs[3];
            sel     = 4'b0110;   // Middle lanes only.
         end else begin
            adrs[i] = $random(seed) & 32'h7FFF_FFFC;
            sel     = 4'hF;
         end
         wdat = $random(seed);
         write_word(adrs[i], wdat, sel);
         shadow[word_idx(adrs[i])] = merge_lanes(shadow[word_idx(adrs[i])], wdat, sel);
      end
      for (int i = 0; i < 10; i++) begin
         read_word(adrs[i], rdat);
         check_word("scratch RAM read", rdat, shadow[word_idx(adrs[i])]);
      end
      end_test("scratch RAM");

      write_word(32'h8000_0040, 32'hDEAD_BEEF, 4'hF);
      check_word("narrow bytes", {nb_mem[8'h40], nb_mem[8'h41], nb_mem[8'h42], nb_mem[8'h43]},
                 32'hDEAD_BEEF);
      read_word(32'h8000_0040, rdat);
      check_word("narrow read", rdat, 32'hDEAD_BEEF);
      read_word(32'h8012_3460, rdat);
      check_word("narrow fill read", rdat,
                 {fill_byte(8'h60), fill_byte(8'h61), fill_byte(8'h62), fill_byte(8'h63)});
      check_word("narrow address", nb_last_adr, 32'h0012_3463);
      end_test("narrow bus");

      write_word(32'h8000_0040, 32'h0102_0304, 4'b0101);
      check_word("narrow partial bytes",
                 {nb_mem[8'h40], nb_mem[8'h41], nb_mem[8'h42], nb_mem[8'h43]}, 32'hDE02_BE04);
      read_word(32'h8000_0040, rdat);
      check_word("narrow partial read", rdat, 32'hDE02_BE04);
      end_test("narrow byte lanes");

      write_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_LED}, 32'h2, 4'hF);
      check_word("LEDs red", {led_red, led_green}, 32'h2);
      write_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_LED}, 32'h1, 4'hF);
      check_word("LEDs green", {led_red, led_green}, 32'h1);
      read_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_LED}, rdat);
      check_word("LED register", rdat, 32'h1);
      write_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_SCRATCH}, 32'h1234_5678, 4'hF);
      write_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_SCRATCH}, 32'hAB00_0000, 4'b1000);
      read_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_SCRATCH}, rdat);
      check_word("scratch register", rdat, 32'hAB34_5678);
      read_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_ID}, rdat);
      check_word("device ID", rdat, `SP_DEVICE_ID);
      write_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_RST}, 32'h16, 4'hF);
      repeat (2) @(negedge clk);
      check_word("soft reset pulses", rst_pulses, 32'd1);
      check_word("soft reset value", rst_value, 32'h16);
      read_word({`SP_MMIO_PAGE, 16'h0, `SP_REG_RST}, rdat);
      check_word("RST register", rdat, 32'h0);
      end_test("MMIO registers");

      write_word(32'hC000_0040, 32'hFFFF_FFFF, 4'hF);
      read_word(32'hC000_0040, rdat);
      check_word("unmapped read", rdat, 32'h0);
      end_test("unmapped address");

      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
